// File: src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// major opcodes, inst[6:0]
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_SYSTEM  7'b1110011

// funct3 codes, inst[14:12]
`define F3_ADDI     3'b000
`define F3_ADD      3'b000
`define F3_LW       3'b010
`define F3_SW       3'b010

// funct7 of add, sub differs here
`define F7_ADD      7'b0000000

// ebreak: imm=1, rs1=x0, funct3=0, rd=x0
`define INST_EBREAK {12'h001, 5'd0, 3'b000, 5'd0, `OPC_SYSTEM}

// addi x0, x0, 0
`define INST_NOP    {12'h000, 5'd0, `F3_ADDI, 5'd0, `OPC_OP_IMM}

// first fetch address
`define RESET_PC    32'h0000_0000

// architectural register count
`define NUM_REGS    32

// enable levels
`define WRITE_ENABLE    1'b1
`define WRITE_DISABLE   1'b0
`define JUMP_ENABLE     1'b1
`define JUMP_DISABLE    1'b0

`define ZERO_WORD   32'h0000_0000

`endif

// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  wmask_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_WB,
        S_HALT
    } ctrl_state_t;

    // decoder to execute unit
    typedef struct packed {
        word_t     op1;
        word_t     op2;
        word_t     op1_jump;
        word_t     op2_jump;
        word_t     rs2_data;
        reg_addr_t rd;
        logic      reg_wen;
        inst_t     inst;
    } exu_req_t;

    // execute unit to regfile and pc
    typedef struct packed {
        logic      jump_en;
        addr_t     jump_addr;
        logic      reg_wen;
        reg_addr_t waddr;
        word_t     wdata;
    } exu_res_t;

    typedef struct packed {
        logic   wen;
        addr_t  waddr;
        word_t  wdata;
        wmask_t wmask;
        addr_t  raddr;
    } dmem_req_t;

endpackage

// File: src/rv_ctrl_fsm.sv
`timescale 1ns/1ps

module rv_ctrl_fsm (
    input  logic clk,
    input  logic rst_i,
    input  logic is_ebreak_i,
    output logic fetch_en_o,
    output logic exec_en_o,
    output logic wb_en_o,
    output logic halted_o
);

    import rv_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // fetch -> exec -> wb, one cycle each
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH: begin
                state_d = S_EXEC;
            end
            S_EXEC: begin
                // ebreak never reaches writeback
                if (is_ebreak_i) begin
                    state_d = S_HALT;
                end else begin
                    state_d = S_WB;
                end
            end
            S_WB: begin
                state_d = S_FETCH;
            end
            S_HALT: begin
                state_d = S_HALT;
            end
            default: begin
                state_d = S_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    // strobes straight from the state
    assign fetch_en_o = (state_q == S_FETCH);
    assign exec_en_o  = (state_q == S_EXEC);
    assign wb_en_o    = (state_q == S_WB);
    assign halted_o   = (state_q == S_HALT);

endmodule

// File: src/rv_pc.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_pc (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             wb_en_i,
    input  rv_pkg::exu_res_t res_i,
    output rv_pkg::addr_t    pc_o,
    output rv_pkg::word_t    instret_o
);

    import rv_pkg::*;

    addr_t pc_q;
    word_t instret_q;
    addr_t pc_next;

    // taken jump wins over sequential advance
    assign pc_next = (res_i.jump_en == `JUMP_ENABLE) ? res_i.jump_addr : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q      <= `RESET_PC;
            instret_q <= '0;
        end else if (wb_en_i) begin
            pc_q      <= pc_next;
            // one retire per writeback
            instret_q <= instret_q + 32'd1;
        end
    end

    assign pc_o      = pc_q;
    assign instret_o = instret_q;

endmodule

// File: src/rv_idu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_idu (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                fetch_en_i,
    input  rv_pkg::inst_t       inst_i,
    input  rv_pkg::addr_t       pc_i,
    input  rv_pkg::word_t       rs1_data_i,
    input  rv_pkg::word_t       rs2_data_i,
    output rv_pkg::reg_addr_t   rs1_o,
    output rv_pkg::reg_addr_t   rs2_o,
    output rv_pkg::exu_req_t    req_o,
    output logic                is_ebreak_o
);

    import rv_pkg::*;

    inst_t      inst_q;
    logic [6:0] opcode;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      imm_j;

    // instruction register, a nop until the first fetch
    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_q <= `INST_NOP;
        end else if (fetch_en_i) begin
            inst_q <= inst_i;
        end
    end

    assign opcode = inst_q[6:0];
    assign rs1_o  = inst_q[19:15];
    assign rs2_o  = inst_q[24:20];

    // sign-extended immediates
    assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_u = {inst_q[31:12], 12'b0};
    assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

    always_comb begin
        req_o          = '0;
        req_o.rs2_data = rs2_data_i;
        req_o.rd       = inst_q[11:7];
        req_o.inst     = inst_q;
        case (opcode)
            `OPC_OP_IMM, `OPC_LOAD: begin
                req_o.op1     = rs1_data_i;
                req_o.op2     = imm_i;
                req_o.reg_wen = `WRITE_ENABLE;
            end
            `OPC_OP: begin
                req_o.op1     = rs1_data_i;
                req_o.op2     = rs2_data_i;
                req_o.reg_wen = `WRITE_ENABLE;
            end
            `OPC_STORE: begin
                req_o.op1 = rs1_data_i;
                req_o.op2 = imm_s;
            end
            `OPC_LUI: begin
                req_o.op1     = `ZERO_WORD;
                req_o.op2     = imm_u;
                req_o.reg_wen = `WRITE_ENABLE;
            end
            `OPC_AUIPC: begin
                req_o.op1     = pc_i;
                req_o.op2     = imm_u;
                req_o.reg_wen = `WRITE_ENABLE;
            end
            `OPC_JAL: begin
                // link value pc+4, target pc+imm
                req_o.op1      = pc_i;
                req_o.op2      = 32'd4;
                req_o.op1_jump = pc_i;
                req_o.op2_jump = imm_j;
                req_o.reg_wen  = `WRITE_ENABLE;
            end
            `OPC_JALR: begin
                req_o.op1      = pc_i;
                req_o.op2      = 32'd4;
                req_o.op1_jump = rs1_data_i;
                req_o.op2_jump = imm_i;
                req_o.reg_wen  = `WRITE_ENABLE;
            end
            default: ;
        endcase
    end

    assign is_ebreak_o = (inst_q == `INST_EBREAK);

endmodule

// File: src/rv_exu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_exu (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              exec_en_i,
    input  rv_pkg::exu_req_t  req_i,
    input  rv_pkg::word_t     dmem_rdata_i,
    output rv_pkg::dmem_req_t dmem_o,
    output rv_pkg::exu_res_t  res_o
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    exu_res_t   res_d;

    logic       jump_en_q;
    logic       reg_wen_q;
    addr_t      jump_addr_q;
    reg_addr_t  waddr_q;
    word_t      wdata_q;

    assign opcode = req_i.inst[6:0];
    assign funct3 = req_i.inst[14:12];

    always_comb begin
        res_d.jump_en   = `JUMP_DISABLE;
        res_d.jump_addr = `ZERO_WORD;
        res_d.reg_wen   = `WRITE_DISABLE;
        res_d.waddr     = req_i.rd;
        res_d.wdata     = `ZERO_WORD;
        dmem_o          = '0;
        case (opcode)
            `OPC_OP_IMM: begin
                if (funct3 == `F3_ADDI) begin
                    res_d.reg_wen = req_i.reg_wen;
                    res_d.wdata   = req_i.op1 + req_i.op2;
                end
            end
            `OPC_OP: begin
                // sub shares funct3 with add
                if (funct3 == `F3_ADD && req_i.inst[31:25] == `F7_ADD) begin
                    res_d.reg_wen = req_i.reg_wen;
                    res_d.wdata   = req_i.op1 + req_i.op2;
                end
            end
            `OPC_LOAD: begin
                if (funct3 == `F3_LW) begin
                    dmem_o.raddr  = req_i.op1 + req_i.op2;
                    res_d.reg_wen = req_i.reg_wen;
                    res_d.wdata   = dmem_rdata_i;
                end
            end
            `OPC_STORE: begin
                if (funct3 == `F3_SW) begin
                    // write strobe only during the execute cycle
                    if (exec_en_i) begin
                        dmem_o.wen = `WRITE_ENABLE;
                    end
                    dmem_o.waddr = req_i.op1 + req_i.op2;
                    dmem_o.wdata = req_i.rs2_data;
                    dmem_o.wmask = 4'b1111;
                end
            end
            `OPC_LUI, `OPC_AUIPC: begin
                res_d.reg_wen = req_i.reg_wen;
                res_d.wdata   = req_i.op1 + req_i.op2;
            end
            `OPC_JAL: begin
                res_d.reg_wen   = req_i.reg_wen;
                res_d.wdata     = req_i.op1 + req_i.op2;
                res_d.jump_en   = `JUMP_ENABLE;
                res_d.jump_addr = req_i.op1_jump + req_i.op2_jump;
            end
            `OPC_JALR: begin
                res_d.reg_wen   = req_i.reg_wen;
                res_d.wdata     = req_i.op1 + req_i.op2;
                res_d.jump_en   = `JUMP_ENABLE;
                res_d.jump_addr = (req_i.op1_jump + req_i.op2_jump) & ~32'd1;
            end
            default: ;
        endcase
    end

    // control bits of the result
    always_ff @(posedge clk) begin
        if (rst_i) begin
            jump_en_q <= `JUMP_DISABLE;
            reg_wen_q <= `WRITE_DISABLE;
        end else if (exec_en_i) begin
            jump_en_q <= res_d.jump_en;
            reg_wen_q <= res_d.reg_wen;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (exec_en_i) begin
            jump_addr_q <= res_d.jump_addr;
            waddr_q     <= res_d.waddr;
            wdata_q     <= res_d.wdata;
        end
    end

    assign res_o.jump_en   = jump_en_q;
    assign res_o.jump_addr = jump_addr_q;
    assign res_o.reg_wen   = reg_wen_q;
    assign res_o.waddr     = waddr_q;
    assign res_o.wdata     = wdata_q;

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::word_t     wdata_i,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    output rv_pkg::word_t     rdata1_o,
    output rv_pkg::word_t     rdata2_o
);

    import rv_pkg::*;

    word_t regs_q [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            // x0 stays zero
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic              clk,
    input  logic              rst_i,
    output rv_pkg::addr_t     imem_addr_o,
    input  rv_pkg::inst_t     imem_data_i,
    output rv_pkg::dmem_req_t dmem_o,
    input  rv_pkg::word_t     dmem_rdata_i,
    output logic              halted_o,
    output rv_pkg::word_t     instret_o
);

    import rv_pkg::*;

    logic      fetch_en;
    logic      exec_en;
    logic      wb_en;
    logic      is_ebreak;
    addr_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    exu_req_t  exu_req;
    exu_res_t  exu_res;

    rv_ctrl_fsm i_ctrl_fsm (
        .clk         (clk),
        .rst_i       (rst_i),
        .is_ebreak_i (is_ebreak),
        .fetch_en_o  (fetch_en),
        .exec_en_o   (exec_en),
        .wb_en_o     (wb_en),
        .halted_o    (halted_o)
    );

    rv_pc i_pc (
        .clk       (clk),
        .rst_i     (rst_i),
        .wb_en_i   (wb_en),
        .res_i     (exu_res),
        .pc_o      (pc),
        .instret_o (instret_o)
    );

    assign imem_addr_o = pc;

    rv_idu i_idu (
        .clk         (clk),
        .rst_i       (rst_i),
        .fetch_en_i  (fetch_en),
        .inst_i      (imem_data_i),
        .pc_i        (pc),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .req_o       (exu_req),
        .is_ebreak_o (is_ebreak)
    );

    rv_exu i_exu (
        .clk          (clk),
        .rst_i        (rst_i),
        .exec_en_i    (exec_en),
        .req_i        (exu_req),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_o       (dmem_o),
        .res_o        (exu_res)
    );

    // writeback only when the result carries a register write
    rv_regfile i_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (wb_en && exu_res.reg_wen),
        .waddr_i  (exu_res.waddr),
        .wdata_i  (exu_res.wdata),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

endmodule

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_core;

    import rv_pkg::*;

    localparam int    CLK_PERIOD    = 10;
    localparam int    RESET_CYCLES  = 5;
    localparam int    IMEM_WORDS    = 64;
    localparam int    DMEM_WORDS    = 256;
    localparam int    PROG_LEN      = 27;
    localparam int    SETTLE_CYCLES = 10;
    localparam addr_t BASE          = 32'h0000_0100;
    localparam addr_t LOAD_A        = 32'h0000_0080;
    localparam addr_t AUIPC_PC      = 32'd16;
    localparam addr_t JAL_PC        = 32'd68;
    localparam addr_t JALR_PC       = 32'd88;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } store_exp_t;

    logic      clk;
    logic      rst;
    addr_t     imem_addr;
    inst_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      halted;
    word_t     instret;

    inst_t      imem [IMEM_WORDS];
    word_t      dmem [DMEM_WORDS];
    inst_t      prog [PROG_LEN];
    store_exp_t store_tbl [$];
    addr_t      fetch_tbl [$];
    word_t      rnd_a;
    word_t      rnd_b;
    addr_t      exp_halt_pc;
    int         store_idx;
    int         fetch_idx;
    int         mismatch_count;
    int         other_errors;

    rv_core i_dut (
        .clk          (clk),
        .rst_i        (rst),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_o       (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .halted_o     (halted),
        .instret_o    (instret)
    );

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.raddr[9:2]];

    always @(posedge clk) begin
        if (dmem_req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wmask[b]) begin
                    dmem[dmem_req.waddr[9:2]][b*8 +: 8] = dmem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // small assembler helpers
    function automatic inst_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_add(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        return {`F7_ADD, rs2, rs1, `F3_ADD, rd, `OPC_OP};
    endfunction

    function automatic inst_t enc_sw(reg_addr_t rs1, reg_addr_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OPC_STORE};
    endfunction

    function automatic inst_t enc_u(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_jal(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    task automatic build_program();
        prog[0]  = enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd1, 5'd0, 12'h123);
        prog[1]  = enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd2, 5'd0, 12'hffb);
        prog[2]  = enc_add(5'd3, 5'd1, 5'd2);
        prog[3]  = enc_u(`OPC_LUI, 5'd4, 20'habcde);
        prog[4]  = enc_u(`OPC_AUIPC, 5'd5, 20'h00001);
        // write to x0 must be dropped
        prog[5]  = enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd0, 5'd1, 12'h007);
        prog[6]  = enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd6, 5'd0, BASE[11:0]);
        prog[7]  = enc_sw(5'd6, 5'd1, 12'd0);
        prog[8]  = enc_sw(5'd6, 5'd2, 12'd4);
        prog[9]  = enc_sw(5'd6, 5'd3, 12'd8);
        prog[10] = enc_sw(5'd6, 5'd4, 12'd12);
        prog[11] = enc_sw(5'd6, 5'd5, 12'd16);
        prog[12] = enc_sw(5'd6, 5'd0, 12'd20);
        prog[13] = enc_i(`OPC_LOAD, `F3_LW, 5'd7, 5'd0, LOAD_A[11:0]);
        prog[14] = enc_i(`OPC_LOAD, `F3_LW, 5'd8, 5'd0, LOAD_A[11:0] + 12'd4);
        prog[15] = enc_sw(5'd6, 5'd7, 12'd24);
        prog[16] = enc_sw(5'd6, 5'd8, 12'hffc);
        prog[17] = enc_jal(5'd9, 21'd12);
        prog[18] = enc_sw(5'd6, 5'd1, 12'd28);
        prog[19] = enc_sw(5'd6, 5'd1, 12'd28);
        prog[20] = enc_sw(5'd6, 5'd9, 12'd28);
        // odd target, jalr drops bit 0
        prog[21] = enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd10, 5'd0, 12'h061);
        prog[22] = enc_i(`OPC_JALR, 3'b000, 5'd11, 5'd10, 12'h000);
        prog[23] = enc_sw(5'd6, 5'd1, 12'd32);
        prog[24] = enc_sw(5'd6, 5'd11, 12'd32);
        prog[25] = `INST_EBREAK;
        prog[26] = enc_sw(5'd6, 5'd1, 12'd36);
        // unused slots hold nops tagged with their index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_LEN) ? prog[i] : enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd0, 5'd0, 12'(i));
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hd00d_0000 | i;
        end
        rnd_a = $urandom();
        rnd_b = $urandom();
        dmem[LOAD_A[9:2]]       = rnd_a;
        dmem[LOAD_A[9:2] + 8'd1] = rnd_b;
    endtask

    task automatic build_expected();
        word_t x1;
        word_t x2;
        addr_t jal_target;
        addr_t jalr_target;
        x1          = 32'h0 + 32'h123;
        x2          = 32'h0 - 32'd5;
        jal_target  = JAL_PC + 32'd12;
        jalr_target = (32'h61 + 32'h0) & ~32'd1;
        exp_halt_pc = jalr_target + 32'd4;
        store_tbl.push_back('{BASE, x1});
        store_tbl.push_back('{BASE + 32'd4, x2});
        store_tbl.push_back('{BASE + 32'd8, x1 + x2});
        store_tbl.push_back('{BASE + 32'd12, 32'habcde << 12});
        store_tbl.push_back('{BASE + 32'd16, AUIPC_PC + (32'h1 << 12)});
        store_tbl.push_back('{BASE + 32'd20, 32'h0});
        store_tbl.push_back('{BASE + 32'd24, rnd_a});
        store_tbl.push_back('{BASE - 32'd4, rnd_b});
        store_tbl.push_back('{BASE + 32'd28, JAL_PC + 32'd4});
        store_tbl.push_back('{BASE + 32'd32, JALR_PC + 32'd4});
        for (addr_t a = 32'd4; a <= JAL_PC; a += 32'd4) begin
            fetch_tbl.push_back(a);
        end
        fetch_tbl.push_back(jal_target);
        fetch_tbl.push_back(jal_target + 32'd4);
        fetch_tbl.push_back(jal_target + 32'd8);
        fetch_tbl.push_back(jalr_target);
        fetch_tbl.push_back(exp_halt_pc);
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s: got %b, expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_store(input dmem_req_t got, input store_exp_t exp);
        if (got.waddr !== exp.addr || got.wdata !== exp.data || got.wmask !== 4'b1111) begin
            $display("MISMATCH t=%0t store: got %h <= %h mask %b, expected %h <= %h mask 1111",
                     $time, got.waddr, got.wdata, got.wmask, exp.addr, exp.data);
            mismatch_count++;
        end
    endtask

    // stores in table order, one fetch move per three cycles
    task automatic watch_bus();
        addr_t last_pc;
        int    cycles_since;
        last_pc      = imem_addr;
        cycles_since = 0;
        forever begin
            @(negedge clk);
            cycles_since++;
            if (dmem_req.wen) begin
                if (store_idx < store_tbl.size()) begin
                    check_store(dmem_req, store_tbl[store_idx]);
                end else begin
                    $display("unexpected extra store to %h at %0t", dmem_req.waddr, $time);
                    other_errors++;
                end
                store_idx++;
            end
            if (imem_addr !== last_pc) begin
                check_word("cycles per instruction", word_t'(cycles_since), 32'd3);
                if (fetch_idx < fetch_tbl.size()) begin
                    check_addr("fetch address", imem_addr, fetch_tbl[fetch_idx]);
                end else begin
                    $display("fetch moved to %h after the last expected address", imem_addr);
                    other_errors++;
                end
                fetch_idx++;
                last_pc      = imem_addr;
                cycles_since = 0;
            end
        end
    endtask

    task automatic finish_run();
        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        rst            = 1'b1;
        store_idx      = 0;
        fetch_idx      = 0;
        mismatch_count = 0;
        other_errors   = 0;
        void'($urandom(32'hb3f));
        build_program();
        build_expected();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_addr("reset pc", imem_addr, `RESET_PC);
        check_flag("dmem wen after reset", dmem_req.wen, 1'b0);
        check_flag("halted after reset", halted, 1'b0);
        fork
            watch_bus();
        join_none
        while (halted !== 1'b1) @(negedge clk);
        repeat (SETTLE_CYCLES) @(negedge clk);
        check_addr("halt address", imem_addr, exp_halt_pc);
        check_flag("halted", halted, 1'b1);
        // every retired instruction moved fetch once
        check_word("instret", instret, word_t'(fetch_tbl.size()));
        if (store_idx < store_tbl.size()) begin
            $display("only %0d of %0d expected stores occurred", store_idx, store_tbl.size());
            other_errors++;
        end
        if (fetch_idx < fetch_tbl.size()) begin
            $display("fetch reached only %0d of %0d addresses", fetch_idx, fetch_tbl.size());
            other_errors++;
        end
        finish_run();
    end

    // program length bounds the run
    initial begin
        repeat (RESET_CYCLES + PROG_LEN * 3 + 50) @(posedge clk);
        $display("timeout, core did not halt within %0d cycles", PROG_LEN * 3 + 50);
        other_errors++;
        finish_run();
    end

endmodule

// File: sim.f
+incdir+src
src/rv_pkg.sv
src/rv_ctrl_fsm.sv
src/rv_pc.sv
src/rv_idu.sv
src/rv_exu.sv
src/rv_regfile.sv
src/rv_core.sv
tests/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_rv_core
FILELIST  := sim.f
FLAGS     := --binary -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
